/* verilog.f */
+incdir+design
design/fetch_pkg.sv
design/pre_if_stage.sv
design/if_stage.sv
design/bpu.sv
design/fetch_frontend.sv
sim/fetch_frontend_props.sv
sim/fetch_frontend_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f \
		--top-module fetch_frontend_tb -o fetch_frontend_sim
	./obj_dir/fetch_frontend_sim | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/fetch_frontend_tb.sv */
`timescale 1ns/1ns
`include "fetch_cfg.svh"

module fetch_frontend_tb;

    localparam logic [31:0] RST = `FETCH_RESET_PC;
    localparam logic [31:0] JMP_PC = RST + 32'd8;
    localparam logic [31:0] JMP_TGT = 32'hbfc0_0100;
    localparam logic [31:0] RDR_PC = 32'hbfc0_0200;
    // per-test budgets in cycles, reset included
    localparam int BUDGET = 60 + 60 + 120 + 4 * 80 + 400;

    logic                 clk;
    logic                 reset;
    logic                 inst_req;
    logic [31:0]          inst_addr;
    logic [31:0]          inst_rdata;
    logic                 icache_busy;
    logic                 ds_allowin;
    logic                 br_valid;
    logic [31:0]          br_pc;
    logic                 br_taken;
    logic [31:0]          br_target;
    logic                 br_flush;
    logic                 flush;
    logic                 fs_to_ds_valid;
    logic [31:0]          fs_pc;
    logic [31:0]          fs_inst;
    logic                 fs_bd;
    logic                 fs_ex;
    fetch_pkg::exc_code_t fs_exc_code;
    logic                 pred_taken;
    logic [31:0]          pred_target;

    logic [31:0] prog [logic [31:0]];
    logic [31:0] q_pc[$];
    logic [31:0] q_inst[$];
    logic        q_bd[$];
    logic        q_ex[$];
    logic [4:0]  q_code[$];
    logic        q_ptaken[$];
    logic [31:0] q_ptarget[$];
    logic        last_fire;
    int          bad_req;
    int          errors;
    int          checks;
    int          tests;
    logic [31:0] rng;

    fetch_frontend u_fetch_frontend (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory model, word one cycle after the request
    always @(posedge clk) begin
        if (inst_req) begin
            inst_rdata <= prog.exists(inst_addr) ? prog[inst_addr] : 32'd0;
        end
    end

    // sample deliveries at negedge, where outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            last_fire = 1'b0;
        end else begin
            if (last_fire) begin
                q_ptaken.push_back(pred_taken);
                q_ptarget.push_back(pred_target);
            end
            last_fire = fs_to_ds_valid && ds_allowin;
            if (last_fire) begin
                q_pc.push_back(fs_pc);
                q_inst.push_back(fs_inst);
                q_bd.push_back(fs_bd);
                q_ex.push_back(fs_ex);
                q_code.push_back(fs_exc_code);
            end
            if (inst_req && inst_addr[1:0] != 2'b00) begin
                bad_req++;
            end
        end
    end

    initial begin
        #(BUDGET * 4 + 800);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_log();
        q_pc.delete();
        q_inst.delete();
        q_bd.delete();
        q_ex.delete();
        q_code.delete();
        q_ptaken.delete();
        q_ptarget.delete();
        bad_req = 0;
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        ds_allowin <= 1'b1;
        icache_busy <= 1'b0;
        repeat (16) @(posedge clk);
        clear_log();
        reset <= 1'b0;
    endtask

    task automatic wait_deliveries(string name, int n, int budget, output logic ok);
        int c;
        c = 0;
        while (q_pc.size() < n && c < budget) begin
            @(posedge clk);
            c++;
        end
        ok = (q_pc.size() >= n);
        if (!ok) begin
            $display("%s: timed out waiting for %0d deliveries, got %0d",
                     name, n, q_pc.size());
            errors++;
        end
    endtask

    task automatic finish_test(string name, int err_before);
        tests++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    function automatic void load_straight();
        prog.delete();
        for (int i = 0; i < 16; i++) begin
            prog[RST + 32'(i * 4)] = 32'h2408_0000 + 32'(i);
        end
    endfunction

    // J at RST+8 whose target sits in the same 256 MB region
    function automatic void load_jump();
        load_straight();
        prog[JMP_PC] = {6'b000010, JMP_TGT[27:2]};
    endfunction

    task automatic test_sequential();
        logic ok;
        int e;
        e = errors;
        load_straight();
        apply_reset();
        wait_deliveries("sequential", 8, 40, ok);
        if (ok) begin
            for (int i = 0; i < 8; i++) begin
                check("sequential pc", RST + 32'(i * 4), q_pc[i]);
                check("sequential inst", 32'h2408_0000 + 32'(i), q_inst[i]);
            end
        end
        finish_test("sequential", e);
    endtask

    task automatic test_jump();
        logic ok;
        int e;
        e = errors;
        load_jump();
        apply_reset();
        wait_deliveries("jump", 6, 40, ok);
        if (ok) begin
            check("jump pc", JMP_PC, q_pc[2]);
            check("jump slot pc", JMP_PC + 32'd4, q_pc[3]);
            check("jump slot bd", 32'd1, 32'(q_bd[3]));
            check("jump target pc", JMP_TGT, q_pc[4]);
            check("jump target bd", 32'd0, 32'(q_bd[4]));
            check("jump after target", JMP_TGT + 32'd4, q_pc[5]);
            check("first pred_taken", 32'd0, 32'(q_ptaken[0]));
            check("jump pred_taken", 32'd1, 32'(q_ptaken[2]));
            check("jump pred_target", JMP_TGT, q_ptarget[2]);
        end
        finish_test("jump", e);
    endtask

    task automatic test_branch_training();
        logic [31:0] beq_tgt;
        logic        ok;
        int          e;
        int          k;
        e = errors;
        // target = slot pc + (imm << 2)
        beq_tgt = JMP_PC + 32'd4 + 32'h40;
        load_straight();
        prog[JMP_PC] = {6'b000100, 5'd1, 5'd2, 16'h0010};
        apply_reset();
        wait_deliveries("branch untrained", 5, 40, ok);
        if (ok) begin
            for (int i = 0; i < 5; i++) begin
                check("untrained pc", RST + 32'(i * 4), q_pc[i]);
            end
            // not taken yet, so decode is told to go on after the delay slot
            check("untrained pred_taken", 32'd0, 32'(q_ptaken[2]));
            check("untrained pred_target", JMP_PC + 32'd8, q_ptarget[2]);
        end
        @(posedge clk);
        br_valid <= 1'b1;
        br_pc <= JMP_PC;
        br_taken <= 1'b1;
        br_target <= beq_tgt;
        repeat (2) @(posedge clk);
        br_valid <= 1'b0;
        // send fetch back to the BEQ
        br_flush <= 1'b1;
        br_target <= JMP_PC;
        clear_log();
        @(posedge clk);
        br_flush <= 1'b0;
        wait_deliveries("branch trained", 8, 40, ok);
        k = -1;
        for (int i = 0; i < q_pc.size() - 2; i++) begin
            if (k < 0 && q_pc[i] == JMP_PC) begin
                k = i;
            end
        end
        if (k < 0) begin
            $display("branch trained: the BEQ was not fetched again");
            errors++;
        end else begin
            check("trained slot pc", JMP_PC + 32'd4, q_pc[k + 1]);
            check("trained target pc", beq_tgt, q_pc[k + 2]);
        end
        finish_test("branch_training", e);
    endtask

    task automatic redirect_case(string name, logic do_flush, logic do_br,
                                 logic [31:0] target, logic [31:0] exp_pc, logic exp_ex);
        logic ok;
        int e;
        e = errors;
        load_straight();
        apply_reset();
        wait_deliveries(name, 3, 40, ok);
        @(posedge clk);
        flush <= do_flush;
        br_flush <= do_br;
        br_target <= target;
        // decode stalls as well, so the killed word waits in IF
        ds_allowin <= 1'b0;
        clear_log();
        @(posedge clk);
        flush <= 1'b0;
        br_flush <= 1'b0;
        ds_allowin <= 1'b1;
        wait_deliveries(name, 2, 20, ok);
        if (ok) begin
            check({name, " bubble inst"}, 32'd0, q_inst[0]);
            check({name, " bubble ex"}, 32'd0, 32'(q_ex[0]));
            check({name, " pc"}, exp_pc, q_pc[1]);
            check({name, " ex"}, 32'(exp_ex), 32'(q_ex[1]));
            check({name, " code"}, exp_ex ? 32'(fetch_pkg::ADEL) : 32'(`FETCH_NO_EX),
                  32'(q_code[1]));
            check({name, " bad requests"}, 32'd0, 32'(bad_req));
        end
        finish_test(name, e);
    endtask

    task automatic test_backpressure();
        logic [31:0] exp_pc;
        logic        ok;
        int          e;
        int          c;
        e = errors;
        load_jump();
        apply_reset();
        c = 0;
        while (q_pc.size() < 24 && c < 360) begin
            @(posedge clk);
            rng = xorshift(rng);
            ds_allowin <= rng[0] | rng[1];
            icache_busy <= rng[2] & rng[3];
            c++;
        end
        ds_allowin <= 1'b1;
        icache_busy <= 1'b0;
        ok = (q_pc.size() >= 24);
        if (!ok) begin
            $display("backpressure: timed out with %0d deliveries", q_pc.size());
            errors++;
        end else begin
            for (int i = 0; i < 24; i++) begin
                // unstalled stream: R, R+4, J, slot, then the jump target onward
                exp_pc = (i < 4) ? RST + 32'(i * 4) : JMP_TGT + 32'((i - 4) * 4);
                check("backpressure pc", exp_pc, q_pc[i]);
            end
        end
        finish_test("backpressure", e);
    endtask

    initial begin
        reset <= 1'b1;
        inst_rdata <= 32'd0;
        icache_busy <= 1'b0;
        ds_allowin <= 1'b1;
        br_valid <= 1'b0;
        br_pc <= 32'd0;
        br_taken <= 1'b0;
        br_target <= 32'd0;
        br_flush <= 1'b0;
        flush <= 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        rng = 32'h0a11_cfb1;
        test_sequential();
        test_jump();
        test_branch_training();
        redirect_case("br_flush", 1'b0, 1'b1, RDR_PC, RDR_PC, 1'b0);
        redirect_case("flush", 1'b1, 1'b0, RDR_PC, `FETCH_EXC_VECTOR, 1'b0);
        redirect_case("both_flush", 1'b1, 1'b1, RDR_PC, `FETCH_EXC_VECTOR, 1'b0);
        redirect_case("misaligned", 1'b0, 1'b1, RDR_PC + 32'd2, RDR_PC + 32'd2, 1'b1);
        test_backpressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sim/fetch_frontend_props.sv */
`timescale 1ns/1ns

module fetch_frontend_props (
    input logic        clk,
    input logic        reset,
    input logic        inst_req,
    input logic [31:0] inst_addr,
    input logic        ds_allowin,
    input logic        flush,
    input logic        br_flush,
    input logic        fs_to_ds_valid,
    input logic [31:0] fs_pc,
    input logic [31:0] fs_inst,
    input logic        fs_bd,
    input logic        fs_ex
);

    // nothing reaches decode straight out of reset
    assert property (@(posedge clk) reset |=> !fs_to_ds_valid)
        else $error("fs_to_ds_valid high in the cycle after reset");

    // decode stalled, so the offered word must not move
    assert property (@(posedge clk) disable iff (reset || flush || br_flush)
        fs_to_ds_valid && !ds_allowin |=> $stable(fs_pc) && $stable(fs_inst) &&
            $stable(fs_bd) && $stable(fs_ex))
        else $error("fetch outputs changed while decode was stalled");

    assert property (@(posedge clk) disable iff (reset)
        inst_req |-> inst_addr[1:0] == 2'b00)
        else $error("instruction request with a misaligned address");

    // the word killed by a flush stays a bubble until decode takes it
    assert property (@(posedge clk) disable iff (reset)
        flush |=> !fs_to_ds_valid || fs_inst == 32'd0)
        else $error("squashed word after flush is not zero");

endmodule

bind fetch_frontend fetch_frontend_props u_fetch_frontend_props (.*);

/* design/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend (
    input  logic                 clk,
    input  logic                 reset,
    // instruction memory
    output logic                 inst_req,
    output logic [31:0]          inst_addr,
    input  logic [31:0]          inst_rdata,
    input  logic                 icache_busy,
    // decode
    input  logic                 ds_allowin,
    input  logic                 br_valid,
    input  logic [31:0]          br_pc,
    input  logic                 br_taken,
    input  logic [31:0]          br_target,
    input  logic                 br_flush,
    input  logic                 flush,
    output logic                 fs_to_ds_valid,
    output logic [31:0]          fs_pc,
    output logic [31:0]          fs_inst,
    output logic                 fs_bd,
    output logic                 fs_ex,
    output fetch_pkg::exc_code_t fs_exc_code,
    output logic                 pred_taken,
    output logic [31:0]          pred_target
);

    logic                 ps_valid;
    logic [31:0]          ps_pc;
    logic                 ps_ex;
    fetch_pkg::exc_code_t ps_exc_code;
    logic                 fs_allowin;
    logic                 fs_fire;
    logic                 predict_valid;
    logic [31:0]          predict_target;

    pre_if_stage u_pre_if_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_allowin     (fs_allowin),
        .flush          (flush),
        .br_flush       (br_flush),
        .br_target      (br_target),
        .predict_valid  (predict_valid),
        .predict_target (predict_target),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .ps_valid       (ps_valid),
        .ps_pc          (ps_pc),
        .ps_ex          (ps_ex),
        .ps_exc_code    (ps_exc_code)
    );

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .ps_valid       (ps_valid),
        .ps_pc          (ps_pc),
        .ps_ex          (ps_ex),
        .ps_exc_code    (ps_exc_code),
        .inst_rdata     (inst_rdata),
        .icache_busy    (icache_busy),
        .ds_allowin     (ds_allowin),
        .flush          (flush),
        .br_flush       (br_flush),
        .fs_allowin     (fs_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_fire        (fs_fire),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_bd          (fs_bd),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code)
    );

    // predicts on the word as it leaves for decode
    bpu u_bpu (
        .clk            (clk),
        .reset          (reset),
        .fs_fire        (fs_fire),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .br_valid       (br_valid),
        .br_pc          (br_pc),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .predict_valid  (predict_valid),
        .predict_target (predict_target),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target)
    );

endmodule

/* design/bpu.sv */
`timescale 1ns/1ns
`include "fetch_cfg.svh"

module bpu (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_fire,
    input  logic [31:0] fs_pc,
    input  logic [31:0] fs_inst,
    input  logic        br_valid,
    input  logic [31:0] br_pc,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    output logic        predict_valid,
    output logic [31:0] predict_target,
    output logic        pred_taken,
    output logic [31:0] pred_target
);

    localparam int DEPTH = `FETCH_BHT_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = 30 - IDX_W;

    logic [1:0]            bht [DEPTH];
    logic [DEPTH-1:0]      btb_valid;
    logic [TAG_W-1:0]      btb_tag [DEPTH];
    logic [31:0]           btb_target [DEPTH];

    fetch_pkg::inst_word_t word;
    logic [IDX_W-1:0]      rd_idx;
    logic [TAG_W-1:0]      rd_tag;
    logic [IDX_W-1:0]      upd_idx;
    logic [TAG_W-1:0]      upd_tag;
    logic [1:0]            upd_ctr;
    logic [1:0]            next_ctr;
    logic                  inst_jump;
    logic                  inst_cond;
    logic                  btb_hit;
    logic                  cond_taken;
    logic [31:0]           slot_pc;
    logic [31:0]           jump_target;
    logic [31:0]           fall_through;

    // lookup on the word leaving IF
    assign word   = fs_inst;
    assign rd_idx = fs_pc[IDX_W+1:2];
    assign rd_tag = fs_pc[31:IDX_W+2];

    assign inst_jump = fetch_pkg::is_jump(word);
    assign inst_cond = fetch_pkg::is_cond_branch(word);

    // J region comes from the delay slot, not the jump itself
    assign slot_pc     = fs_pc + 32'd4;
    assign jump_target = {slot_pc[31:28], word.j.index, 2'b00};

    // not taken resumes after the delay slot
    assign fall_through = (inst_jump || inst_cond) ? fs_pc + 32'd8 : slot_pc;

    assign btb_hit    = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
    assign cond_taken = inst_cond && bht[rd_idx][1] && btb_hit;

    assign predict_valid  = fs_fire && (inst_jump || cond_taken);
    assign predict_target = inst_jump ? jump_target : btb_target[rd_idx];

    // copy for decode, valid alongside decode's own stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            pred_taken <= 1'b0;
        end else if (fs_fire) begin
            pred_taken <= predict_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_fire) begin
            pred_target <= predict_valid ? predict_target : fall_through;
        end
    end

    // training from resolved branches
    assign upd_idx = br_pc[IDX_W+1:2];
    assign upd_tag = br_pc[31:IDX_W+2];
    assign upd_ctr = bht[upd_idx];

    always_comb begin
        if (br_taken) begin
            next_ctr = (upd_ctr == 2'b11) ? upd_ctr : upd_ctr + 2'b01;
        end else begin
            next_ctr = (upd_ctr == 2'b00) ? upd_ctr : upd_ctr - 2'b01;
        end
    end

    // weakly not taken out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                bht[i] <= 2'b01;
            end
            btb_valid <= '0;
        end else if (br_valid) begin
            bht[upd_idx] <= next_ctr;
            if (br_taken) begin
                btb_valid[upd_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br_valid && br_taken) begin
            btb_tag[upd_idx]    <= upd_tag;
            btb_target[upd_idx] <= br_target;
        end
    end

endmodule

/* design/if_stage.sv */
`timescale 1ns/1ns

module if_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ps_valid,
    input  logic [31:0]          ps_pc,
    input  logic                 ps_ex,
    input  fetch_pkg::exc_code_t ps_exc_code,
    input  logic [31:0]          inst_rdata,
    input  logic                 icache_busy,
    input  logic                 ds_allowin,
    input  logic                 flush,
    input  logic                 br_flush,
    output logic                 fs_allowin,
    output logic                 fs_to_ds_valid,
    output logic                 fs_fire,
    output logic [31:0]          fs_pc,
    output logic [31:0]          fs_inst,
    output logic                 fs_bd,
    output logic                 fs_ex,
    output fetch_pkg::exc_code_t fs_exc_code
);

    logic                  fs_valid;
    logic                  fs_ready_go;
    logic                  ps_fire;
    logic [31:0]           fs_pc_r;
    logic                  fs_ex_r;
    fetch_pkg::exc_code_t  fs_exc_code_r;
    logic                  fresh;
    logic [31:0]           inst_hold;
    logic [31:0]           raw_word;
    logic                  squash_r;
    logic                  squash;
    logic                  branch_seen;
    fetch_pkg::inst_word_t fs_word;

    // memory busy keeps the word from completing
    assign fs_ready_go    = !icache_busy;
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_valid && fs_ready_go;
    assign fs_fire        = fs_to_ds_valid && ds_allowin;
    assign ps_fire        = ps_valid && fs_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= ps_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ps_fire) begin
            fs_pc_r <= ps_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_ex_r       <= 1'b0;
            fs_exc_code_r <= fetch_pkg::NONE;
        end else if (ps_fire) begin
            fs_ex_r       <= ps_ex;
            fs_exc_code_r <= ps_exc_code;
        end
    end

    // rdata is sampled exactly one cycle after the request
    // later cycles of a stall read the copy
    always_ff @(posedge clk) begin
        if (reset) begin
            fresh <= 1'b0;
        end else begin
            fresh <= ps_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fresh) begin
            inst_hold <= inst_rdata;
        end
    end

    assign raw_word = fresh ? inst_rdata : inst_hold;

    // word in IF at a flush leaves as a bubble
    // mark stays until the next fetch enters
    always_ff @(posedge clk) begin
        if (reset) begin
            squash_r <= 1'b0;
        end else if (ps_fire) begin
            squash_r <= 1'b0;
        end else if (flush || br_flush) begin
            squash_r <= 1'b1;
        end
    end

    assign squash = squash_r || flush || br_flush;

    // address error entries never had a request, so no word
    assign fs_inst     = (squash || fs_ex_r) ? 32'd0 : raw_word;
    assign fs_pc       = fs_pc_r;
    assign fs_ex       = fs_ex_r && !squash;
    assign fs_exc_code = fs_ex ? fs_exc_code_r : fetch_pkg::NONE;

    assign fs_word = fs_inst;

    // a jump or branch leaving now makes the next word its delay slot
    always_ff @(posedge clk) begin
        if (reset) begin
            branch_seen <= 1'b0;
        end else if (flush) begin
            branch_seen <= 1'b0;
        end else if (fs_fire) begin
            branch_seen <= fetch_pkg::is_jump(fs_word) || fetch_pkg::is_cond_branch(fs_word);
        end
    end

    assign fs_bd = fs_valid && branch_seen && !squash;

endmodule

/* design/pre_if_stage.sv */
`timescale 1ns/1ns
`include "fetch_cfg.svh"

module pre_if_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fs_allowin,
    input  logic                 flush,
    input  logic                 br_flush,
    input  logic [31:0]          br_target,
    input  logic                 predict_valid,
    input  logic [31:0]          predict_target,
    output logic                 inst_req,
    output logic [31:0]          inst_addr,
    output logic                 ps_valid,
    output logic [31:0]          ps_pc,
    output logic                 ps_ex,
    output fetch_pkg::exc_code_t ps_exc_code
);

    logic [31:0] pc;
    logic        pc_valid;
    logic        redirect_now;
    logic        misaligned;
    logic        ps_fire;
    logic [31:0] seq_pc;

    // exception and mispredict throw away the current pc at once
    assign redirect_now = flush || br_flush;

    assign seq_pc     = pc + 32'd4;
    assign misaligned = (pc[1:0] != 2'b00);

    assign ps_valid = pc_valid && !redirect_now;
    assign ps_fire  = ps_valid && fs_allowin;

    // request only when IF takes the pc this cycle, never for a bad address
    assign inst_req    = ps_fire && !misaligned;
    assign inst_addr   = pc;
    assign ps_pc       = pc;
    assign ps_ex       = misaligned;
    assign ps_exc_code = misaligned ? fetch_pkg::ADEL : fetch_pkg::NONE;

    // pc and redirect priority: flush, br_flush, prediction, +4
    // a prediction arrives while the delay slot leaves, so it lands right after the slot
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `FETCH_RESET_PC;
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= 1'b1;
            if (flush) begin
                pc <= `FETCH_EXC_VECTOR;
            end else if (br_flush) begin
                pc <= br_target;
            end else if (ps_fire) begin
                pc <= predict_valid ? predict_target : seq_pc;
            end
        end
    end

endmodule

/* design/fetch_pkg.sv */
`include "fetch_cfg.svh"

package fetch_pkg;

    // jump format, J and JAL
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_view_t;

    // immediate format, conditional branches
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_view_t;

    typedef union packed {
        j_view_t j;
        i_view_t i;
    } inst_word_t;

    // ADEL follows the MIPS cause encoding
    typedef enum logic [4:0] {
        ADEL = 5'h04,
        NONE = `FETCH_NO_EX
    } exc_code_t;

    // J = 000010, JAL = 000011
    function automatic logic is_jump(inst_word_t w);
        return w.j.opcode[5:1] == 5'b00001;
    endfunction

    // BEQ/BNE any rt, BLEZ/BGTZ only with rt zero
    function automatic logic is_cond_branch(inst_word_t w);
        return (w.i.opcode[5:1] == 5'b00010) ||
               (w.i.opcode[5:1] == 5'b00011 && w.i.rt == 5'd0);
    endfunction

endpackage

/* design/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address after reset, in the boot ROM segment
`define FETCH_RESET_PC 32'hbfc0_0000

// general exception entry
`define FETCH_EXC_VECTOR 32'hbfc0_0380

// counter table and target buffer entries
// must be a power of two, at least 2
`define FETCH_BHT_DEPTH 64

// exception code carried when nothing went wrong
`define FETCH_NO_EX 5'h1f

`endif
